/* files.f */
design/snakePkg.sv
design/snakeBody.sv
design/appleTracker.sv
design/frameSequencer.sv
design/snakeTop.sv
bench/frameBufferModel.sv
bench/snakeTb.sv

/* bench/snakeTb.sv */
`timescale 1ns/10ps
/* One full game on the default geometry: initial draw, five moves left, three up onto the
   apple, then up into the top wall. Expected frames come from a reference model here. */
module snakeTb;
    import snakePkg::*;

    localparam int MaxLength = DefaultMaxLength;
    localparam int SegSize = DefaultSegSize;
    localparam int AppleSize = DefaultAppleSize;
    localparam int CreditDepth = DefaultCreditDepth;
    localparam int WaitLimit = 5000;

    logic        Clock;
    logic        reset;
    logic        start;
    logic        tick;
    logic        dirValid;
    logic        creditReturn;
    direction_t  direction;
    pixelWrite_t pixel;
    logic        pixelValid;
    logic        gameOver;
    scoreCount_t score;

    int   errorCount;
    int   timeoutCount;
    logic aborted;
    int   writeCount;
    int   inFlight;

    // reference game state
    int         refX [MaxLength];
    int         refY [MaxLength];
    int         appleIndex;
    int         refScore;
    direction_t refDir;
    int         appleTableX [7] = '{30, 10, 70, 60, 20, 50, 80};
    int         appleTableY [7] = '{30, 20, 90, 100, 80, 10, 50};

    snakeTop #(
        .MaxLength(MaxLength),
        .SegSize(SegSize),
        .AppleSize(AppleSize),
        .CreditDepth(CreditDepth)
    ) dut (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .tick(tick),
        .dirValid(dirValid),
        .creditReturn(creditReturn),
        .direction(direction),
        .pixel(pixel),
        .pixelValid(pixelValid),
        .gameOver(gameOver),
        .score(score)
    );

    frameBufferModel frameBuffer (
        .Clock(Clock),
        .reset(reset),
        .pixel(pixel),
        .pixelValid(pixelValid),
        .creditReturn(creditReturn)
    );

    initial
    begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // writes accepted and writes not yet handed back
    always @(posedge Clock)
    begin
        if (reset)
        begin
            writeCount = 0;
            inFlight = 0;
        end
        else
        begin
            if (pixelValid)
                writeCount = writeCount + 1;
            inFlight = inFlight + int'(pixelValid) - int'(creditReturn);
        end
    end

    creditLimit: assert property (@(posedge Clock) disable iff (reset)
        inFlight <= CreditDepth)
    else
    begin
        errorCount++;
        $display("Error at %0t: inFlight expected at most %0d got %0d",
            $time, CreditDepth, inFlight);
    end

    quietAfterOver: assert property (@(posedge Clock) disable iff (reset)
        gameOver |-> !pixelValid)
    else
    begin
        errorCount++;
        $display("Pixel write seen at %0t after the game was over", $time);
    end

    overHolds: assert property (@(posedge Clock) disable iff (reset)
        gameOver |=> gameOver)
    else
    begin
        errorCount++;
        $display("gameOver dropped again at %0t", $time);
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected)
        else
        begin
            errorCount++;
            $display("Error at %0t: %s expected %0d got %0d", $time, name, expected, got);
        end
    endtask

    task automatic checkSquare(input int x0, input int y0, input int size,
                               input colour_t colour);
        int      badPixels;
        int      badX;
        int      badY;
        colour_t seen;
        badPixels = 0;
        badX = x0;
        badY = y0;
        seen = colour;
        for (int y = y0; y < y0 + size; y++)
        begin
            for (int x = x0; x < x0 + size; x++)
            begin
                if (frameBuffer.frame[x][y] !== colour)
                begin
                    if (badPixels == 0)
                    begin
                        badX = x;
                        badY = y;
                        seen = frameBuffer.frame[x][y];
                    end
                    badPixels++;
                end
            end
        end
        assert (badPixels == 0)
        else
        begin
            errorCount++;
            $display("Error at %0t: frame[%0d][%0d] expected %0h got %0h, %0d pixels wrong",
                $time, badX, badY, colour, seen, badPixels);
        end
    endtask

    task automatic reportTimeout(input string what);
        timeoutCount++;
        aborted = 1'b1;
        $display("Timed out at %0t while waiting for %s", $time, what);
    endtask

    task automatic waitWrites(input int target, input string what);
        int cycles;
        cycles = 0;
        while (writeCount < target && cycles < WaitLimit)
        begin
            @(posedge Clock);
            #1;
            cycles++;
        end
        if (writeCount < target)
            reportTimeout(what);
    endtask

    task automatic pulseTick();
        tick = 1'b1;
        @(posedge Clock);
        #1;
        tick = 1'b0;
    endtask

    // sequencer needs a couple of cycles to see nextHead change
    task automatic setDirection(input direction_t dir);
        direction = dir;
        dirValid = 1'b1;
        @(posedge Clock);
        #1;
        dirValid = 1'b0;
        refDir = dir;
        repeat (3) @(posedge Clock);
        #1;
    endtask

    task automatic initialDraw();
        int total;
        total = AppleSize * AppleSize + MaxLength * SegSize * SegSize;
        for (int i = 0; i < MaxLength; i++)
        begin
            refX[i] = 80;
            refY[i] = 60 + i * SegSize;
        end
        start = 1'b1;
        @(posedge Clock);
        #1;
        start = 1'b0;
        waitWrites(total, "the initial draw");
        if (!aborted)
        begin
            // nothing more until a direction and a tick
            repeat (20) @(posedge Clock);
            #1;
            checkValue("writeCount", writeCount, total);
            checkSquare(appleTableX[0], appleTableY[0], AppleSize, AppleColour);
            for (int i = 0; i < MaxLength; i++)
                checkSquare(refX[i], refY[i], SegSize, SnakeColour);
        end
    endtask

    // one game tick against the reference rules
    task automatic doTick(output logic hit);
        int   headX;
        int   headY;
        int   oldX;
        int   oldY;
        int   startCount;
        int   cycles;
        logic eats;
        headX = refX[0];
        headY = refY[0];
        case (refDir)
            DirRight: headX = headX + SegSize;
            DirDown:  headY = headY + SegSize;
            DirUp:    headY = headY - SegSize;
            default:  headX = headX - SegSize;
        endcase
        hit = (headX < 0) || (headY < 0) || (headX + SegSize > ScreenWidth) ||
              (headY + SegSize > ScreenHeight);
        // tail leaves its cell on the same step
        for (int i = 1; i < MaxLength - 1; i++)
        begin
            if (headX == refX[i] && headY == refY[i])
                hit = 1'b1;
        end
        eats = !hit && headX == appleTableX[appleIndex] && headY == appleTableY[appleIndex];
        startCount = writeCount;
        pulseTick();
        if (hit)
        begin
            cycles = 0;
            while (!gameOver && cycles < 20)
            begin
                @(posedge Clock);
                #1;
                cycles++;
            end
            if (!gameOver)
                reportTimeout("gameOver after a collision");
            checkValue("writeCount", writeCount, startCount);
        end
        else
        begin
            waitWrites(startCount + 2 * SegSize * SegSize + (eats ? AppleSize * AppleSize : 0),
                "the writes of a tick");
            repeat (3) @(posedge Clock);
            #1;
            oldX = refX[MaxLength-1];
            oldY = refY[MaxLength-1];
            for (int i = MaxLength - 1; i > 0; i--)
            begin
                refX[i] = refX[i-1];
                refY[i] = refY[i-1];
            end
            refX[0] = headX;
            refY[0] = headY;
            if (eats)
            begin
                appleIndex = (appleIndex + 1) % 7;
                refScore++;
            end
            if (!aborted)
            begin
                checkValue("writeCount", writeCount,
                    startCount + 2 * SegSize * SegSize + (eats ? AppleSize * AppleSize : 0));
                checkSquare(headX, headY, SegSize, SnakeColour);
                checkSquare(oldX, oldY, SegSize, EraseColour);
                if (eats)
                    checkSquare(appleTableX[appleIndex], appleTableY[appleIndex], AppleSize,
                        AppleColour);
                checkValue("score", score, refScore);
                checkValue("gameOver", gameOver, 0);
            end
        end
    endtask

    task automatic moveAndEat();
        logic hit;
        setDirection(DirLeft);
        for (int i = 0; i < 5 && !aborted; i++)
            doTick(hit);
        setDirection(DirUp);
        for (int i = 0; i < 3 && !aborted; i++)
            doTick(hit);
        if (!aborted)
        begin
            checkValue("score", score, 1);
            checkSquare(10, 20, AppleSize, AppleColour);
        end
    endtask

    task automatic hitWall();
        logic hit;
        int   ticks;
        int   frozen;
        hit = 1'b0;
        ticks = 0;
        while (!hit && !aborted && ticks < 20)
        begin
            doTick(hit);
            ticks++;
        end
        if (!hit && !aborted)
        begin
            errorCount++;
            $display("The snake never reached the top wall");
        end
        if (hit && !aborted)
        begin
            frozen = writeCount;
            for (int i = 0; i < 50; i++)
            begin
                pulseTick();
                repeat (2) @(posedge Clock);
                #1;
            end
            checkValue("writeCount", writeCount, frozen);
            checkValue("gameOver", gameOver, 1);
        end
    endtask

    initial
    begin
        errorCount = 0;
        timeoutCount = 0;
        aborted = 1'b0;
        writeCount = 0;
        inFlight = 0;
        appleIndex = 0;
        refScore = 0;
        refDir = DirUp;
        reset = 1'b1;
        start = 1'b0;
        tick = 1'b0;
        dirValid = 1'b0;
        direction = DirRight;
        repeat (8) @(posedge Clock);
        #1;
        reset = 1'b0;
        checkValue("pixelValid", pixelValid, 0);
        checkValue("gameOver", gameOver, 0);
        checkValue("score", score, 0);
        initialDraw();
        if (!aborted)
            moveAndEat();
        if (!aborted)
            hitWall();
        $display("Run ended with %0d errors and %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* bench/frameBufferModel.sv */
`timescale 1ns/10ps
/* Frame buffer stand-in. Each accepted write comes back as one credit after 0 to 3
   idle cycles, and at most one credit returns per cycle. */
module frameBufferModel (
    input  logic                  Clock,
    input  logic                  reset,
    input  snakePkg::pixelWrite_t pixel,
    input  logic                  pixelValid,
    output logic                  creditReturn
);
    import snakePkg::*;

    // read by the testbench through the instance path
    colour_t frame [ScreenWidth][ScreenHeight];
    integer  seed;
    int      pending;
    int      holdCycles;
    logic    returning;

    initial
    begin
        seed = 32'h354d_36d1;
        pending = 0;
        holdCycles = 0;
        creditReturn = 1'b0;
    end

    always @(posedge Clock)
    begin
        returning = 1'b0;
        if (reset)
        begin
            pending = 0;
            holdCycles = 0;
        end
        else
        begin
            if (pixelValid)
            begin
                frame[pixel.point.x][pixel.point.y] = pixel.colour;
                pending = pending + 1;
            end
            // one consumed write per return, random gap between returns
            if (pending > 0)
            begin
                if (holdCycles == 0)
                begin
                    returning = 1'b1;
                    pending = pending - 1;
                    holdCycles = $random(seed) & 3;
                end
                else
                    holdCycles = holdCycles - 1;
            end
        end
        #1 creditReturn = returning;
    end

endmodule

/* design/snakeTop.sv */
`timescale 1ns/10ps
/* Snake engine with a credit-gated pixel stream. The frame buffer has to return one
   credit per write, and it gets no more than CreditDepth writes in flight. */
module snakeTop #(
    parameter int MaxLength = snakePkg::DefaultMaxLength,
    parameter int SegSize = snakePkg::DefaultSegSize,
    parameter int AppleSize = snakePkg::DefaultAppleSize,
    parameter int CreditDepth = snakePkg::DefaultCreditDepth
) (
    input  logic                  Clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  tick,
    input  logic                  dirValid,
    input  logic                  creditReturn,
    input  snakePkg::direction_t  direction,
    output snakePkg::pixelWrite_t pixel,
    output logic                  pixelValid,
    output logic                  gameOver,
    output snakePkg::scoreCount_t score
);
    import snakePkg::*;

    point_t                       nextHead;
    point_t                       tail;
    point_t                       segment;
    point_t                       apple;
    logic                         collision;
    logic                         appleMoved;
    logic                         step;
    logic [$clog2(MaxLength)-1:0] segIndex;

    snakeBody #(
        .MaxLength(MaxLength),
        .SegSize(SegSize)
    ) body (
        .Clock(Clock),
        .reset(reset),
        .step(step),
        .dirValid(dirValid),
        .direction(direction),
        .segIndex(segIndex),
        .nextHead(nextHead),
        .tail(tail),
        .segment(segment),
        .collision(collision)
    );

    // works on the same nextHead as the body
    appleTracker #(
        .AppleSize(AppleSize)
    ) appleUnit (
        .Clock(Clock),
        .reset(reset),
        .step(step),
        .nextHead(nextHead),
        .apple(apple),
        .appleMoved(appleMoved),
        .score(score)
    );

    frameSequencer #(
        .MaxLength(MaxLength),
        .SegSize(SegSize),
        .AppleSize(AppleSize),
        .CreditDepth(CreditDepth)
    ) sequencer (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .tick(tick),
        .collision(collision),
        .appleMoved(appleMoved),
        .creditReturn(creditReturn),
        .nextHead(nextHead),
        .tail(tail),
        .segment(segment),
        .apple(apple),
        .step(step),
        .segIndex(segIndex),
        .pixel(pixel),
        .pixelValid(pixelValid),
        .gameOver(gameOver)
    );

endmodule

/* design/frameSequencer.sv */
`timescale 1ns/10ps
/* Writes squares pixel by pixel in row-major order, one pixel per credit.
   Ticks are only taken in the running state. Once the game is over nothing more is written. */
module frameSequencer #(
    parameter int MaxLength = snakePkg::DefaultMaxLength,
    parameter int SegSize = snakePkg::DefaultSegSize,
    parameter int AppleSize = snakePkg::DefaultAppleSize,
    parameter int CreditDepth = snakePkg::DefaultCreditDepth
) (
    input  logic                         Clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         tick,
    input  logic                         collision,
    input  logic                         appleMoved,
    input  logic                         creditReturn,
    input  snakePkg::point_t             nextHead,
    input  snakePkg::point_t             tail,
    input  snakePkg::point_t             segment,
    input  snakePkg::point_t             apple,
    output logic                         step,
    output logic [$clog2(MaxLength)-1:0] segIndex,
    output snakePkg::pixelWrite_t        pixel,
    output logic                         pixelValid,
    output logic                         gameOver
);
    import snakePkg::*;

    localparam int IndexWidth = $clog2(MaxLength);
    localparam int CreditWidth = $clog2(CreditDepth + 1);

    typedef enum logic [3:0] {
        StIdle,
        StInitApple,
        StInitBody,
        StWaitDir,
        StRun,
        StErase,
        StStep,
        StHead,
        StApple,
        StOver
    } state_t;

    state_t                 state;
    logic [IndexWidth-1:0]  bodyIndex;
    logic [7:0]             colOffset;
    logic [7:0]             rowOffset;
    logic [7:0]             squareSize;
    point_t                 origin;
    colour_t                squareColour;
    logic                   drawing;
    logic                   issue;
    logic                   lastPixel;
    logic                   squareDone;
    logic                   applePending;
    logic [CreditWidth-1:0] creditCount;

    // square source for the current state
    always_comb
    begin
        drawing = 1'b1;
        origin = segment;
        squareSize = 8'(SegSize);
        squareColour = SnakeColour;
        case (state)
            StInitApple, StApple:
            begin
                origin = apple;
                squareSize = 8'(AppleSize);
                squareColour = AppleColour;
            end
            StErase:
            begin
                origin = tail;
                squareColour = EraseColour;
            end
            StInitBody, StHead:
                drawing = 1'b1;
            default:
                drawing = 1'b0;
        endcase
    end

    // head is index 0 outside the initial draw
    assign segIndex = (state == StInitBody) ? bodyIndex : '0;

    assign issue = drawing && (creditCount != '0);
    assign lastPixel = (colOffset == squareSize - 8'd1) && (rowOffset == squareSize - 8'd1);
    assign squareDone = issue && lastPixel;

    assign pixelValid = issue;
    always_comb
    begin
        pixel.point.x = origin.x + xCoord_t'(colOffset);
        pixel.point.y = origin.y + yCoord_t'(rowOffset);
        pixel.colour = squareColour;
    end

    assign step = (state == StStep) && !collision;
    assign gameOver = (state == StOver);

    // rasterizer stalls with the credits
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            colOffset <= '0;
            rowOffset <= '0;
        end
        else if (issue)
        begin
            if (colOffset == squareSize - 8'd1)
            begin
                colOffset <= '0;
                rowOffset <= lastPixel ? 8'd0 : rowOffset + 8'd1;
            end
            else
                colOffset <= colOffset + 8'd1;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
            creditCount <= CreditWidth'(CreditDepth);
        else
            creditCount <= creditCount - CreditWidth'(issue) + CreditWidth'(creditReturn);
    end

    // appleMoved comes while the head is still being drawn
    always_ff @(posedge Clock)
    begin
        if (reset)
            applePending <= 1'b0;
        else if (appleMoved)
            applePending <= 1'b1;
        else if (state == StApple && squareDone)
            applePending <= 1'b0;
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= StIdle;
            bodyIndex <= '0;
        end
        else
        begin
            case (state)
                StIdle:
                    if (start)
                        state <= StInitApple;
                StInitApple:
                    if (squareDone)
                        state <= StInitBody;
                StInitBody:
                    if (squareDone)
                    begin
                        if (bodyIndex == IndexWidth'(MaxLength - 1))
                        begin
                            bodyIndex <= '0;
                            state <= StWaitDir;
                        end
                        else
                            bodyIndex <= bodyIndex + 1'b1;
                    end
                // first direction shows up as nextHead leaving the head
                StWaitDir:
                    if (nextHead != segment)
                        state <= StRun;
                StRun:
                    if (tick)
                        state <= collision ? StOver : StErase;
                StErase:
                    if (squareDone)
                        state <= StStep;
                // a late direction change may still collide here
                StStep:
                    state <= collision ? StOver : StHead;
                StHead:
                    if (squareDone)
                        state <= (applePending || appleMoved) ? StApple : StRun;
                StApple:
                    if (squareDone)
                        state <= StRun;
                StOver:
                    state <= StOver;
                default:
                    state <= StIdle;
            endcase
        end
    end

    // downstream never hands back more than it was given
    creditBound: assert property (@(posedge Clock) disable iff (reset)
        creditCount <= CreditWidth'(CreditDepth));

endmodule

/* design/appleTracker.sv */
`timescale 1ns/10ps
/* The apple walks through the fixed table in the package, one entry per apple eaten.
   The score wraps at 256. AppleSize only bounds the on-screen check. */
module appleTracker #(
    parameter int AppleSize = snakePkg::DefaultAppleSize
) (
    input  logic                  Clock,
    input  logic                  reset,
    input  logic                  step,
    input  snakePkg::point_t      nextHead,
    output snakePkg::point_t      apple,
    output logic                  appleMoved,
    output snakePkg::scoreCount_t score
);
    import snakePkg::*;

    logic [2:0] tableIndex;
    logic       eat;

    assign apple = ApplePosition(tableIndex);

    // head lands exactly on the apple cell
    assign eat = (nextHead == apple);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            tableIndex <= 3'd0;
            score <= '0;
            appleMoved <= 1'b0;
        end
        else
        begin
            appleMoved <= step && eat;
            if (step && eat)
            begin
                if (tableIndex == 3'(AppleTableSize - 1))
                    tableIndex <= 3'd0;
                else
                    tableIndex <= tableIndex + 3'd1;
                score <= score + scoreCount_t'(1);
            end
        end
    end

    // every table entry has to fit the whole apple square on screen
    appleOnScreen: assert property (@(posedge Clock) disable iff (reset)
        (int'(apple.x) + AppleSize <= ScreenWidth) &&
        (int'(apple.y) + AppleSize <= ScreenHeight));

endmodule

/* design/snakeBody.sv */
`timescale 1ns/10ps
/* The snake has a fixed length, with segments SegSize apart. nextHead stays on the head
   until the first direction arrives. The tail is left out of the self check. */
module snakeBody #(
    parameter int MaxLength = snakePkg::DefaultMaxLength,
    parameter int SegSize = snakePkg::DefaultSegSize
) (
    input  logic                         Clock,
    input  logic                         reset,
    input  logic                         step,
    input  logic                         dirValid,
    input  snakePkg::direction_t         direction,
    input  logic [$clog2(MaxLength)-1:0] segIndex,
    output snakePkg::point_t             nextHead,
    output snakePkg::point_t             tail,
    output snakePkg::point_t             segment,
    output logic                         collision
);
    import snakePkg::*;

    point_t     segments [MaxLength];
    point_t     head;
    direction_t heading;
    logic       moving;
    logic       wallHit;
    logic       bodyHit;

    assign head = segments[0];
    assign tail = segments[MaxLength-1];
    assign segment = segments[segIndex];

    // direction is kept until the next dirValid
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            heading <= DirUp;
            moving <= 1'b0;
        end
        else if (dirValid)
        begin
            heading <= direction;
            moving <= 1'b1;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < MaxLength; i++)
            begin
                segments[i].x <= StartHead.x;
                segments[i].y <= StartHead.y + yCoord_t'(i * SegSize);
            end
        end
        else if (step)
        begin
            // each segment takes the place of the one ahead of it
            segments[0] <= nextHead;
            for (int i = 1; i < MaxLength; i++)
            begin
                segments[i] <= segments[i-1];
            end
        end
    end

    // wall test looks at the far edge of the new square
    always_comb
    begin
        nextHead = head;
        wallHit = 1'b0;
        if (moving)
        begin
            case (heading)
                DirRight:
                begin
                    nextHead.x = head.x + xCoord_t'(SegSize);
                    wallHit = int'(head.x) + 2 * SegSize > ScreenWidth;
                end
                DirDown:
                begin
                    nextHead.y = head.y + yCoord_t'(SegSize);
                    wallHit = int'(head.y) + 2 * SegSize > ScreenHeight;
                end
                DirUp:
                begin
                    nextHead.y = head.y - yCoord_t'(SegSize);
                    wallHit = int'(head.y) < SegSize;
                end
                default:
                begin
                    nextHead.x = head.x - xCoord_t'(SegSize);
                    wallHit = int'(head.x) < SegSize;
                end
            endcase
        end
    end

    // tail moves away on the same step
    always_comb
    begin
        bodyHit = 1'b0;
        for (int i = 1; i < MaxLength - 1; i++)
        begin
            if (nextHead == segments[i])
                bodyHit = 1'b1;
        end
    end

    assign collision = wallHit || bodyHit;

    // the sequencer must stop the game instead of stepping into a collision
    stepSafe: assert property (@(posedge Clock) disable iff (reset) step |-> !collision);

endmodule

/* design/snakePkg.sv */
/* Shared types for the snake engine. The screen is 160 by 120 pixels and coordinates never
   go negative. The apple table has seven entries, and index 7 falls back to the first one. */
package snakePkg;

    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;

    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;

    typedef struct packed {
        xCoord_t x;
        yCoord_t y;
    } point_t;

    typedef logic [2:0] colour_t;

    // one entry of the pixel stream
    typedef struct packed {
        point_t  point;
        colour_t colour;
    } pixelWrite_t;

    typedef enum logic [1:0] {
        DirRight = 2'd0,
        DirDown  = 2'd1,
        DirUp    = 2'd2,
        DirLeft  = 2'd3
    } direction_t;

    typedef logic [7:0] scoreCount_t;

    localparam colour_t SnakeColour = 3'b010;
    localparam colour_t AppleColour = 3'b100;
    localparam colour_t EraseColour = 3'b000;

    // body starts below the head, one segment apart
    localparam point_t StartHead = '{x: 8'd80, y: 7'd60};

    localparam int AppleTableSize = 7;

    function automatic point_t ApplePosition(input logic [2:0] index);
        point_t position;
        case (index)
            3'd1:    position = '{x: 8'd10, y: 7'd20};
            3'd2:    position = '{x: 8'd70, y: 7'd90};
            3'd3:    position = '{x: 8'd60, y: 7'd100};
            3'd4:    position = '{x: 8'd20, y: 7'd80};
            3'd5:    position = '{x: 8'd50, y: 7'd10};
            3'd6:    position = '{x: 8'd80, y: 7'd50};
            default: position = '{x: 8'd30, y: 7'd30};
        endcase
        return position;
    endfunction

    localparam int DefaultMaxLength = 6;
    localparam int DefaultSegSize = 10;
    localparam int DefaultAppleSize = 4;
    localparam int DefaultCreditDepth = 4;

endpackage
